/* design/ghtPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// gshare table geometry: 8 banks x 32 rows x 256 counters.
// Index = fetch ^ (history << 8); bank {7:6,0}, row 5:1, entry 15:8
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package ghtPkg;

    localparam int NumBanks    = 8;
    localparam int NumRows     = 32;
    localparam int RowEntries  = 256;
    localparam int ClearCycles = 32;

    typedef logic [15:0] tableIndex_t;
    typedef logic [15:0] fetchAddr_t;
    typedef logic [7:0]  history_t;
    // bit 1 set means predict taken
    typedef logic [1:0]  counter_t;
    typedef logic [2:0]  bankSel_t;
    typedef logic [4:0]  rowSel_t;
    typedef logic [7:0]  entrySel_t;

    function automatic bankSel_t bankOf(input tableIndex_t index);
        return {index[7:6], index[0]};
    endfunction

    function automatic rowSel_t rowOf(input tableIndex_t index);
        return index[5:1];
    endfunction

    function automatic entrySel_t entryOf(input tableIndex_t index);
        return index[15:8];
    endfunction

    // history only folds into the upper byte
    function automatic tableIndex_t hashIndex(input fetchAddr_t fetchAddr,
                                              input history_t history);
        return fetchAddr ^ {history, 8'b0};
    endfunction

endpackage

`default_nettype wire

/* design/ghtWriteIf.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One bank's write command. wen and clear are never
// high together; clear zeroes the whole row.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

interface ghtWriteIf
    import ghtPkg::*;
();

    logic      wen;
    logic      clear;
    rowSel_t   row;
    // entry and counter only matter with wen
    entrySel_t entry;
    counter_t  counter;

    modport sched (
        output wen,
        output clear,
        output row,
        output entry,
        output counter
    );

    modport bank (
        input wen,
        input clear,
        input row,
        input entry,
        input counter
    );

endinterface

`default_nettype wire

/* design/ghtBank.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Counter storage of one bank, no reset on the array.
// Read is combinational and write-first; reads as zero while clear is up.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ghtBank
    import ghtPkg::*;
(
    input  logic       clk,
    ghtWriteIf.bank    wr,
    input  rowSel_t    rdRow,
    input  entrySel_t  rdEntry,
    output counter_t   rdCounter
);

    counter_t mem [NumRows][RowEntries];

    always_ff @(posedge clk) begin
        if (wr.clear) begin
            // zero every counter of the row
            for (int e = 0; e < RowEntries; e++) begin
                mem[wr.row][e] <= '0;
            end
        end else if (wr.wen) begin
            mem[wr.row][wr.entry] <= wr.counter;
        end
    end

    // clear only comes from the post-reset sweep, when the
    // table is not yet initialised and must read as zero
    assign rdCounter = wr.clear ? counter_t'(0) : mem[rdRow][rdEntry];

endmodule

`default_nettype wire

/* design/ghtLookup.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One lookup per strobe, result valid the following cycle.
// Index held between strobes; predCounter only meaningful with predValid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ghtLookup
    import ghtPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       lookupValid,
    input  fetchAddr_t fetchAddr,
    input  history_t   history,
    output rowSel_t    rdRow,
    output entrySel_t  rdEntry,
    input  counter_t   bankCounters [NumBanks],
    output logic       predValid,
    output counter_t   predCounter
);

    tableIndex_t lookupIndex;
    bankSel_t    lookupBank;

    always_ff @(posedge clk) begin
        if (rst) begin
            predValid <= 1'b0;
        end else begin
            predValid <= lookupValid;
        end
    end

    // hashed index of the latest strobe
    always_ff @(posedge clk) begin
        if (lookupValid) begin
            lookupIndex <= hashIndex(fetchAddr, history);
        end
    end

    // row and entry go to all banks at once
    assign rdRow   = rowOf(lookupIndex);
    assign rdEntry = entryOf(lookupIndex);

    assign lookupBank  = bankOf(lookupIndex);
    assign predCounter = bankCounters[lookupBank];

endmodule

`default_nettype wire

/* design/ghtWriteSched.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clear sweep, then two update ports onto eight banks.
// Same-bank conflicts use a one-entry save buffer which may drop updates.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ghtWriteSched
    import ghtPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        write0Valid,
    input  logic        write1Valid,
    input  tableIndex_t write0Index,
    input  tableIndex_t write1Index,
    input  counter_t    write0Counter,
    input  counter_t    write1Counter,
    output logic        ready,
    ghtWriteIf.sched    bankWr [NumBanks]
);

    logic        sweeping;
    rowSel_t     sweepRow;

    logic        hasSaved;
    tableIndex_t savedIndex;
    counter_t    savedCounter;
    bankSel_t    savedBank;

    logic        write0Go;
    logic        write1Go;
    bankSel_t    bank0;
    bankSel_t    bank1;
    logic        save0;
    logic        save1;

    // one row of every bank cleared per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            sweeping <= 1'b1;
            sweepRow <= '0;
        end else if (sweeping) begin
            sweepRow <= sweepRow + rowSel_t'(1);
            if (sweepRow == rowSel_t'(ClearCycles - 1)) begin
                sweeping <= 1'b0;
            end
        end
    end

    assign ready = ~sweeping;

    // updates are ignored until the sweep is done
    assign write0Go  = write0Valid && ready;
    assign write1Go  = write1Valid && ready;
    assign bank0     = bankOf(write0Index);
    assign bank1     = bankOf(write1Index);
    assign savedBank = bankOf(savedIndex);

    // write0 onto the saved bank replaces the buffer
    assign save0 = hasSaved && write0Go && bank0 == savedBank;

    always_comb begin
        if (!hasSaved) begin
            save1 = write0Go && write1Go && bank0 == bank1;
        end else begin
            save1 = write1Go && !save0 &&
                    (bank1 == savedBank || (write0Go && bank1 == bank0));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hasSaved <= 1'b0;
        end else begin
            hasSaved <= save0 || save1;
        end
    end

    always_ff @(posedge clk) begin
        if (save0) begin
            savedIndex   <= write0Index;
            savedCounter <= write0Counter;
        end else if (save1) begin
            savedIndex   <= write1Index;
            savedCounter <= write1Counter;
        end
    end

    // at most one write per bank; a held write blocks both ports
    for (genvar b = 0; b < NumBanks; b++) begin : gRoute
        logic        useSaved;
        logic        use0;
        logic        use1;
        tableIndex_t selIndex;
        counter_t    selCounter;

        assign useSaved = hasSaved && savedBank == bankSel_t'(b);
        assign use0     = !hasSaved && write0Go && bank0 == bankSel_t'(b);
        assign use1     = !hasSaved && write1Go && bank1 == bankSel_t'(b) && !use0;

        always_comb begin
            if (useSaved) begin
                selIndex   = savedIndex;
                selCounter = savedCounter;
            end else if (use0) begin
                selIndex   = write0Index;
                selCounter = write0Counter;
            end else begin
                selIndex   = write1Index;
                selCounter = write1Counter;
            end
        end

        assign bankWr[b].clear   = sweeping;
        assign bankWr[b].wen     = useSaved || use0 || use1;
        assign bankWr[b].row     = sweeping ? sweepRow : rowOf(selIndex);
        assign bankWr[b].entry   = entryOf(selIndex);
        assign bankWr[b].counter = selCounter;
    end

endmodule

`default_nettype wire

/* design/ghtTop.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// gshare counter table. Writes ignored until ready;
// no back-pressure, so colliding updates may be dropped.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ghtTop
    import ghtPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        lookupValid,
    input  fetchAddr_t  fetchAddr,
    input  history_t    history,
    input  logic        write0Valid,
    input  logic        write1Valid,
    input  tableIndex_t write0Index,
    input  tableIndex_t write1Index,
    input  counter_t    write0Counter,
    input  counter_t    write1Counter,
    output logic        ready,
    output logic        predValid,
    output counter_t    predCounter
);

    rowSel_t   rdRow;
    entrySel_t rdEntry;
    counter_t  bankCounters [NumBanks];

    ghtWriteIf bankWr [NumBanks] ();

    ghtLookup uLookup (
        .clk          (clk),
        .rst          (rst),
        .lookupValid  (lookupValid),
        .fetchAddr    (fetchAddr),
        .history      (history),
        .rdRow        (rdRow),
        .rdEntry      (rdEntry),
        .bankCounters (bankCounters),
        .predValid    (predValid),
        .predCounter  (predCounter)
    );

    ghtWriteSched uWriteSched (
        .clk           (clk),
        .rst           (rst),
        .write0Valid   (write0Valid),
        .write1Valid   (write1Valid),
        .write0Index   (write0Index),
        .write1Index   (write1Index),
        .write0Counter (write0Counter),
        .write1Counter (write1Counter),
        .ready         (ready),
        .bankWr        (bankWr)
    );

    // all banks share the read row and entry
    for (genvar b = 0; b < NumBanks; b++) begin : gBank
        ghtBank uBank (
            .clk       (clk),
            .wr        (bankWr[b]),
            .rdRow     (rdRow),
            .rdEntry   (rdEntry),
            .rdCounter (bankCounters[b])
        );
    end

endmodule

`default_nettype wire

/* verification/ghtTop_asserts.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bound onto ghtTop. predValid protocol and ready
// holding once the clear sweep is done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ghtTopAsserts (
    input logic clk,
    input logic rst,
    input logic lookupValid,
    input logic ready,
    input logic predValid
);

    // a result only in the cycle after a strobe
    predAfterStrobe: assert property (
        @(posedge clk) disable iff (rst) predValid |-> $past(lookupValid)
    ) else $error("predValid high without a lookup strobe one cycle earlier");

    readyHolds: assert property (
        @(posedge clk) disable iff (rst) $past(ready) |-> ready
    ) else $error("ready fell after it had risen");

    // synchronous reset, so one edge of lag
    predQuietInReset: assert property (
        @(posedge clk) $past(rst) |-> !predValid
    ) else $error("predValid high while in reset");

endmodule

bind ghtTop ghtTopAsserts asserts0 (
    .clk         (clk),
    .rst         (rst),
    .lookupValid (lookupValid),
    .ready       (ready),
    .predValid   (predValid)
);

`default_nettype wire

/* verification/ghtTb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for ghtTop. The model keeps the full table and the save buffer.
// Inputs change 10 units after each rising edge; outputs are compared at negedge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ghtTb
    import ghtPkg::*;
();

    localparam int ClkPeriod    = 100;
    localparam int DriveDelay   = 10;
    localparam int ZeroLookups  = 40;
    localparam int RandomCycles = 400;
    // reset, sweep and the two long tests plus room for the directed ones
    localparam int CycleLimit   = 3 + ClearCycles + ZeroLookups + RandomCycles + 60;

    logic        clk;
    logic        rst;
    logic        lookupValid;
    fetchAddr_t  fetchAddr;
    history_t    history;
    logic        write0Valid;
    logic        write1Valid;
    tableIndex_t write0Index;
    tableIndex_t write1Index;
    counter_t    write0Counter;
    counter_t    write1Counter;
    logic        ready;
    logic        predValid;
    counter_t    predCounter;

    // reference model state
    counter_t    refTable [65536];
    logic        savedValid;
    tableIndex_t savedIdx;
    counter_t    savedCtr;
    int          sweepCount;
    logic        expValid;
    counter_t    expCounter;

    int          errorCount = 0;
    int          checkCount = 0;
    int          testCount = 0;
    int          cycleCount = 0;
    int          startErrors;
    int          edges;
    logic [15:0] lfsrState = 16'd42083;

    ghtTop dut0 (
        .clk           (clk),
        .rst           (rst),
        .lookupValid   (lookupValid),
        .fetchAddr     (fetchAddr),
        .history       (history),
        .write0Valid   (write0Valid),
        .write1Valid   (write1Valid),
        .write0Index   (write0Index),
        .write1Index   (write1Index),
        .write0Counter (write0Counter),
        .write1Counter (write1Counter),
        .ready         (ready),
        .predValid     (predValid),
        .predCounter   (predCounter)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(ClkPeriod / 2) clk = ~clk;
        end
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] bits;
        logic        lsb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lsb = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (lsb) begin
                lfsrState = lfsrState ^ 16'hB400;
            end
            bits = {bits[30:0], lsb};
        end
        return bits;
    endfunction

    function automatic tableIndex_t hashOf(input fetchAddr_t fa, input history_t h);
        return fa ^ {h, 8'h00};
    endfunction

    function automatic bankSel_t bankNum(input tableIndex_t idx);
        return {idx[7:6], idx[0]};
    endfunction

    // 64 indices over all 8 banks so updates collide often
    function automatic tableIndex_t pickIndex();
        logic [5:0] r;
        r = 6'(randomBits(6));
        return {6'h00, r[5:4], r[3:2], 4'h0, r[1:0]};
    endfunction

    // commit rules for one edge and the counter a lookup at this edge sees
    function automatic counter_t applyEdge();
        bankSel_t b0;
        bankSel_t b1;
        bankSel_t bs;
        b0 = bankNum(write0Index);
        b1 = bankNum(write1Index);
        bs = bankNum(savedIdx);
        if (sweepCount < ClearCycles) begin
            sweepCount++;
        end else if (!savedValid) begin
            if (write0Valid) begin
                refTable[write0Index] = write0Counter;
            end
            if (write1Valid && write0Valid && b1 == b0) begin
                savedValid = 1'b1;
                savedIdx = write1Index;
                savedCtr = write1Counter;
            end else if (write1Valid) begin
                refTable[write1Index] = write1Counter;
            end
        end else begin
            // only the held write commits while the rest is saved or lost
            refTable[savedIdx] = savedCtr;
            if (write0Valid && b0 == bs) begin
                savedIdx = write0Index;
                savedCtr = write0Counter;
            end else if (write1Valid && (b1 == bs || (write0Valid && b1 == b0))) begin
                savedIdx = write1Index;
                savedCtr = write1Counter;
            end else begin
                savedValid = 1'b0;
            end
        end
        return refTable[hashOf(fetchAddr, history)];
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            savedValid = 1'b0;
            sweepCount = 0;
            expValid = 1'b0;
            for (int i = 0; i < 65536; i++) begin
                refTable[i] = '0;
            end
        end else begin
            expCounter = applyEdge();
            expValid = lookupValid;
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (predValid && !expValid) begin
                $display("predValid went high without a lookup strobe one cycle earlier");
                errorCount++;
            end else if (expValid && !predValid) begin
                $display("a lookup strobe got no result on predValid");
                errorCount++;
            end else if (expValid) begin
                checkCount++;
                if (predCounter !== expCounter) begin
                    $display("[ERROR] predCounter expected %h got %h", expCounter, predCounter);
                    errorCount++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CycleLimit) begin
            $display("timeout, the run went past %0d cycles", CycleLimit);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #DriveDelay;
    endtask

    task automatic clearInputs();
        lookupValid = 1'b0;
        write0Valid = 1'b0;
        write1Valid = 1'b0;
    endtask

    task automatic lookupAt(input tableIndex_t idx);
        history_t h;
        h = history_t'(randomBits(8));
        lookupValid = 1'b1;
        history = h;
        fetchAddr = idx ^ {h, 8'h00};
    endtask

    // two idle edges let the last result reach the compare
    task automatic finishTest(input string name, input int firstError);
        nextCycle();
        clearInputs();
        nextCycle();
        testCount++;
        if (errorCount == firstError) begin
            $display("test %0d %s: ok", testCount, name);
        end else begin
            $display("test %0d %s: FAILED, %0d errors", testCount, name,
                     errorCount - firstError);
        end
    endtask

    initial begin
        rst = 1'b1;
        clearInputs();
        fetchAddr = '0;
        history = '0;
        write0Index = '0;
        write1Index = '0;
        write0Counter = '0;
        write1Counter = '0;
        repeat (3) @(posedge clk);
        #DriveDelay;
        rst = 1'b0;

        startErrors = errorCount;
        edges = 0;
        // lookups while the sweep runs must read zero
        while (!ready && edges <= ClearCycles + 4) begin
            lookupValid = 1'b1;
            fetchAddr = fetchAddr_t'(randomBits(16));
            history = history_t'(randomBits(8));
            nextCycle();
            edges++;
        end
        clearInputs();
        nextCycle();
        if (edges != ClearCycles) begin
            $display("ready rose %0d cycles after reset release instead of %0d",
                     edges, ClearCycles);
            errorCount++;
        end
        testCount++;
        if (errorCount == startErrors) begin
            $display("test %0d clear sweep and ready: ok", testCount);
        end else begin
            $display("test %0d clear sweep and ready: FAILED", testCount);
        end

        startErrors = errorCount;
        for (int i = 0; i < ZeroLookups; i++) begin
            nextCycle();
            clearInputs();
            lookupValid = 1'b1;
            fetchAddr = fetchAddr_t'(randomBits(16));
            history = history_t'(randomBits(8));
        end
        finishTest("lookups after sweep read zero", startErrors);

        startErrors = errorCount;
        nextCycle();
        write0Valid = 1'b1;
        write0Index = 16'h3A5C;
        write0Counter = 2'd2;
        nextCycle();
        clearInputs();
        lookupAt(16'h3A5C);
        nextCycle();
        clearInputs();
        // write and lookup on the same edge
        write1Valid = 1'b1;
        write1Index = 16'h3A5C;
        write1Counter = 2'd3;
        lookupAt(16'h3A5C);
        finishTest("single write then lookup", startErrors);

        startErrors = errorCount;
        nextCycle();
        // both in bank 1 on different rows
        write0Valid = 1'b1;
        write0Index = 16'h1203;
        write0Counter = 2'd1;
        write1Valid = 1'b1;
        write1Index = 16'h4513;
        write1Counter = 2'd2;
        lookupAt(16'h4513);
        nextCycle();
        clearInputs();
        lookupAt(16'h4513);
        nextCycle();
        clearInputs();
        lookupAt(16'h1203);
        finishTest("same-bank pair through save buffer", startErrors);

        startErrors = errorCount;
        for (int i = 0; i < RandomCycles; i++) begin
            nextCycle();
            clearInputs();
            write0Valid = (randomBits(2) != 0);
            write0Index = pickIndex();
            write0Counter = counter_t'(randomBits(2));
            write1Valid = (randomBits(2) != 0);
            write1Index = pickIndex();
            write1Counter = counter_t'(randomBits(2));
            if (1'(randomBits(1))) begin
                lookupAt(pickIndex());
            end
        end
        finishTest("random writes and lookups", startErrors);

        $display("%0d tests, %0d predictions checked, %0d errors",
                 testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
design/ghtPkg.sv
design/ghtWriteIf.sv
design/ghtBank.sv
design/ghtLookup.sv
design/ghtWriteSched.sv
design/ghtTop.sv
verification/ghtTop_asserts.sv
verification/ghtTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = ghtTb
FILELIST  = filelist.f
OBJDIR    = obj_dir
PASS_MSG  = All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
